/* Makefile */
# Verilator flow for the nRF24L01 transmit controller
TOP = nrf_tx_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f vlog.f --top-module $(TOP)

obj_dir/V$(TOP): vlog.f hdl/*.sv hdl/*.svh sim/*.sv
	verilator --binary --timing --assert -f vlog.f --top-module $(TOP)

sim: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) > sim.log 2>&1; status=$$?; cat sim.log; \
	if [ $$status -ne 0 ] || grep -q "Something failed" sim.log; then \
	  echo "simulation did not pass, see sim.log"; exit 1; \
	fi

clean:
	rm -rf obj_dir sim.log

/* hdl/nrf_config.svh */
// timing and sizing constants for the nRF24L01 transmit controller, included by RTL and testbench
`ifndef NRF_CONFIG_SVH
`define NRF_CONFIG_SVH

//////////////////////////////////////////////////
// spi timing
//////////////////////////////////////////////////

`define NRF_SCK_HALF 4      // clk cycles per sck half period
`define NRF_CSN_GAP 6       // csn high time between frames, in clk cycles

//////////////////////////////////////////////////
// radio delays, scaled down for simulation
//////////////////////////////////////////////////

`define NRF_PWR_ON_WAIT 200 // reset release to ce high (12 ms on the board)
`define NRF_TX_SETTLE 100   // payload frame to status read

//////////////////////////////////////////////////
// sizing
//////////////////////////////////////////////////

`define NRF_FIFO_DEPTH 4    // spi items in flight between sequencer and master
`define NRF_ADDR_BYTES 5    // tx address length, matches SETUP_AW = 3

`endif

/* hdl/nrf_link_pkg.sv */
// item format passed from the command sequencer through the FIFO to the SPI master
`default_nettype none

package nrf_link_pkg;

  // one spi byte plus framing control, 10 bits
  typedef struct packed {
    logic [7:0] data;    // shifted out msb first
    logic       last;    // csn rises after this byte
    logic       capture; // miso byte of this slot goes to status
  } spi_item_t;

endpackage

`default_nettype wire

/* hdl/nrf_reg_pkg.sv */
// nRF24L01 command codes, register map and the fixed transmitter setup values
`default_nettype none

package nrf_reg_pkg;

  //////////////////////////////////////////////////
  // spi commands
  //////////////////////////////////////////////////
  localparam logic [7:0] cmd_r_register   = 8'h00; // 000a_aaaa, address in low bits
  localparam logic [7:0] cmd_w_register   = 8'h20; // 001a_aaaa
  localparam logic [7:0] cmd_w_tx_payload = 8'hA0; // payload bytes follow
  localparam logic [7:0] cmd_flush_tx     = 8'hE1; // single byte frame
  localparam logic [7:0] cmd_nop          = 8'hFF; // clocks out status

  //////////////////////////////////////////////////
  // register addresses
  //////////////////////////////////////////////////
  localparam logic [7:0] reg_config     = 8'h00;
  localparam logic [7:0] reg_en_aa      = 8'h01;
  localparam logic [7:0] reg_en_rxaddr  = 8'h02;
  localparam logic [7:0] reg_setup_aw   = 8'h03;
  localparam logic [7:0] reg_setup_retr = 8'h04;
  localparam logic [7:0] reg_rf_ch      = 8'h05;
  localparam logic [7:0] reg_rf_setup   = 8'h06;
  localparam logic [7:0] reg_status     = 8'h07;
  localparam logic [7:0] reg_tx_addr    = 8'h10;
  localparam logic [7:0] reg_rx_pw_p0   = 8'h11;

  //////////////////////////////////////////////////
  // setup values
  //////////////////////////////////////////////////
  localparam logic [7:0] cfg_config       = 8'h1E; // 2 byte crc, pwr_up, ptx
  localparam logic [7:0] cfg_en_aa        = 8'h00; // auto ack off
  localparam logic [7:0] cfg_en_rxaddr    = 8'h01; // pipe 0 only
  localparam logic [7:0] cfg_setup_aw     = 8'h03; // 5 byte address
  localparam logic [7:0] cfg_rf_ch        = 8'h01; // 2.401 GHz
  localparam logic [7:0] cfg_rf_setup     = 8'h07; // 1 Mbps, 0 dBm
  localparam logic [7:0] cfg_setup_retr   = 8'h00; // no retransmit
  localparam logic [7:0] cfg_rx_pw_p0     = 8'h01; // 1 byte payload
  localparam logic [7:0] cfg_status_clear = 8'h70; // write 1 to clear irq flags
  localparam logic [7:0] cfg_tx_addr_byte = 8'hED; // every address byte

endpackage

`default_nettype wire

/* hdl/nrf_spi_master.sv */
// SPI mode 0 master: one byte per item, csn framing with gap, miso capture into status
`default_nettype none
`include "nrf_config.svh"

module nrf_spi_master (
  input  wire logic                    clk,
  input  wire logic                    reset,
  input  wire nrf_link_pkg::spi_item_t item,
  input  wire logic                    item_valid,
  output logic                         item_ready,
  output logic                         spi_sck,
  output logic                         spi_csn,
  output logic                         spi_mosi,
  input  wire logic                    spi_miso,
  output logic [7:0]                   status,
  output logic                         status_valid
);

  typedef enum logic [1:0] {m_idle, m_low, m_high, m_gap} master_state_t;

  localparam int cnt_max = (`NRF_SCK_HALF > `NRF_CSN_GAP) ? `NRF_SCK_HALF : `NRF_CSN_GAP;
  localparam int cnt_w = $clog2(cnt_max + 1);

  master_state_t    state;
  logic [cnt_w-1:0] cnt;      // half period and gap timer
  logic [2:0]       bit_cnt;  // bits done in this byte
  logic [7:0]       tx_sr;    // remaining mosi bits
  logic [7:0]       rx_sr;    // miso collected msb first
  logic             last_q;
  logic             capture_q;

  assign item_ready = (state == m_idle); // one byte at a time

  //////////////////////////////////////////////////
  // bit engine
  //////////////////////////////////////////////////
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      state <= m_idle;
      cnt <= '0;
      bit_cnt <= '0;
      spi_sck <= 1'b0;
      spi_csn <= 1'b1;
      spi_mosi <= 1'b0;
      status_valid <= 1'b0;
    end else begin
      status_valid <= 1'b0;
      case (state)
        m_idle: begin
          if (item_valid) begin
            spi_csn <= 1'b0;         // opens frame, no-op inside one
            spi_mosi <= item.data[7];
            cnt <= '0;
            bit_cnt <= '0;
            state <= m_low;
          end
        end
        m_low: begin
          if (cnt == cnt_w'(`NRF_SCK_HALF - 1)) begin
            cnt <= '0;
            spi_sck <= 1'b1;         // slave and master both sample here
            state <= m_high;
          end else begin
            cnt <= cnt + 1'b1;
          end
        end
        m_high: begin
          if (cnt == cnt_w'(`NRF_SCK_HALF - 1)) begin
            cnt <= '0;
            spi_sck <= 1'b0;
            if (bit_cnt != 3'd7) begin
              spi_mosi <= tx_sr[7];  // next bit set up on falling sck
              bit_cnt <= bit_cnt + 1'b1;
              state <= m_low;
            end else begin
              status_valid <= capture_q;
              if (last_q) begin
                spi_csn <= 1'b1;
                state <= m_gap;
              end else begin
                state <= m_idle;     // csn held low for next byte
              end
            end
          end else begin
            cnt <= cnt + 1'b1;
          end
        end
        default: begin // inter-frame gap
          if (cnt == cnt_w'(`NRF_CSN_GAP - 1)) begin
            cnt <= '0;
            state <= m_idle;
          end else begin
            cnt <= cnt + 1'b1;
          end
        end
      endcase
    end
  end

  //////////////////////////////////////////////////
  // data path
  //////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (state == m_idle && item_valid) begin
      tx_sr <= {item.data[6:0], 1'b0};
      last_q <= item.last;
      capture_q <= item.capture;
    end
    if (state == m_low && cnt == cnt_w'(`NRF_SCK_HALF - 1)) begin
      rx_sr <= {rx_sr[6:0], spi_miso};
    end
    if (state == m_high && cnt == cnt_w'(`NRF_SCK_HALF - 1)) begin
      if (bit_cnt != 3'd7) tx_sr <= {tx_sr[6:0], 1'b0};
      else if (capture_q) status <= rx_sr; // full byte already shifted in
    end
  end

endmodule

`default_nettype wire

/* hdl/nrf_tx_sequencer.sv */
// producer FSM: power-on wait, register setup frames, then one transmit pass per host byte
`default_nettype none
`include "nrf_config.svh"

module nrf_tx_sequencer (
  input  wire logic                     clk,
  input  wire logic                     reset,
  input  wire logic [7:0]               payload,
  input  wire logic                     payload_valid,
  output logic                          payload_ready,
  output nrf_link_pkg::spi_item_t       item,
  output logic                          item_valid,
  input  wire logic                     item_ready,
  output logic                          spi_ce
);

  typedef enum logic [3:0] {
    st_pwr, st_cfg, st_addr, st_idle, st_flush, st_clear, st_load, st_settle, st_read
  } seq_state_t;

  localparam int wait_max = (`NRF_PWR_ON_WAIT > `NRF_TX_SETTLE) ?
                            `NRF_PWR_ON_WAIT : `NRF_TX_SETTLE;
  localparam int wait_w = $clog2(wait_max + 1);
  localparam int idx_w = $clog2(`NRF_ADDR_BYTES + 1);

  seq_state_t        state;
  logic [wait_w-1:0] wait_cnt;   // power-on and settle delay
  logic [2:0]        cfg_idx;    // setup table row
  logic [idx_w-1:0]  byte_idx;   // byte within current frame
  logic [7:0]        payload_q;  // byte of the running pass
  logic [15:0]       cfg_entry;  // {address, value}

  // setup table in write order
  function automatic logic [15:0] cfg_table(input logic [2:0] idx);
    case (idx)
      3'd0: cfg_table = {nrf_reg_pkg::reg_config, nrf_reg_pkg::cfg_config};
      3'd1: cfg_table = {nrf_reg_pkg::reg_en_aa, nrf_reg_pkg::cfg_en_aa};
      3'd2: cfg_table = {nrf_reg_pkg::reg_en_rxaddr, nrf_reg_pkg::cfg_en_rxaddr};
      3'd3: cfg_table = {nrf_reg_pkg::reg_setup_aw, nrf_reg_pkg::cfg_setup_aw};
      3'd4: cfg_table = {nrf_reg_pkg::reg_rf_ch, nrf_reg_pkg::cfg_rf_ch};
      3'd5: cfg_table = {nrf_reg_pkg::reg_rf_setup, nrf_reg_pkg::cfg_rf_setup};
      3'd6: cfg_table = {nrf_reg_pkg::reg_setup_retr, nrf_reg_pkg::cfg_setup_retr};
      default: cfg_table = {nrf_reg_pkg::reg_rx_pw_p0, nrf_reg_pkg::cfg_rx_pw_p0};
    endcase
  endfunction

  assign cfg_entry = cfg_table(cfg_idx);
  assign payload_ready = (state == st_idle); // host waits while a pass runs
  assign item_valid = (state inside {st_cfg, st_addr, st_flush, st_clear, st_load, st_read});

  //////////////////////////////////////////////////
  // frame contents
  //////////////////////////////////////////////////
  always_comb begin
    item = '0;
    case (state)
      st_cfg: begin
        item.data = (byte_idx == '0) ? (nrf_reg_pkg::cmd_w_register | cfg_entry[15:8])
                                     : cfg_entry[7:0];
        item.last = (byte_idx != '0);
      end
      st_addr: begin // command then address bytes
        item.data = (byte_idx == '0) ?
                    (nrf_reg_pkg::cmd_w_register | nrf_reg_pkg::reg_tx_addr) :
                    nrf_reg_pkg::cfg_tx_addr_byte;
        item.last = (byte_idx == idx_w'(`NRF_ADDR_BYTES));
      end
      st_flush: begin
        item.data = nrf_reg_pkg::cmd_flush_tx;
        item.last = 1'b1;
      end
      st_clear: begin // drop tx_ds, max_rt, rx_dr
        item.data = (byte_idx == '0) ? (nrf_reg_pkg::cmd_w_register | nrf_reg_pkg::reg_status)
                                     : nrf_reg_pkg::cfg_status_clear;
        item.last = (byte_idx != '0);
      end
      st_load: begin
        item.data = (byte_idx == '0) ? nrf_reg_pkg::cmd_w_tx_payload : payload_q;
        item.last = (byte_idx != '0);
      end
      st_read: begin // status comes back during the nop
        item.data = (byte_idx == '0) ? (nrf_reg_pkg::cmd_r_register | nrf_reg_pkg::reg_status)
                                     : nrf_reg_pkg::cmd_nop;
        item.last = (byte_idx != '0);
        item.capture = (byte_idx != '0);
      end
      default: ;
    endcase
  end

  //////////////////////////////////////////////////
  // phase control
  //////////////////////////////////////////////////
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      state <= st_pwr;
      wait_cnt <= '0;
      cfg_idx <= '0;
      byte_idx <= '0;
      spi_ce <= 1'b0;
    end else begin
      case (state)
        st_pwr: begin
          if (wait_cnt == wait_w'(`NRF_PWR_ON_WAIT - 1)) begin
            wait_cnt <= '0;
            spi_ce <= 1'b1; // stays high, tx fires whenever fifo has data
            state <= st_cfg;
          end else begin
            wait_cnt <= wait_cnt + 1'b1;
          end
        end
        st_idle: if (payload_valid) state <= st_flush;
        st_settle: begin
          if (wait_cnt == wait_w'(`NRF_TX_SETTLE - 1)) begin
            wait_cnt <= '0;
            state <= st_read;
          end else begin
            wait_cnt <= wait_cnt + 1'b1;
          end
        end
        default: begin
          if (item_valid && item_ready) begin
            if (item.last) begin
              byte_idx <= '0;
              case (state)
                st_cfg: begin
                  cfg_idx <= cfg_idx + 1'b1;
                  if (cfg_idx == 3'd7) state <= st_addr;
                end
                st_flush: state <= st_clear;
                st_clear: state <= st_load;
                st_load: state <= st_settle;
                default: state <= st_idle; // address frame or status read done
              endcase
            end else begin
              byte_idx <= byte_idx + 1'b1;
            end
          end
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (payload_valid && payload_ready) payload_q <= payload;
  end

endmodule

`default_nettype wire

/* hdl/nrf_tx_top.sv */
// top level of the nRF24L01 transmit controller: sequencer, item FIFO and SPI master
`default_nettype none
`include "nrf_config.svh"

module nrf_tx_top (
  input  wire logic       clk,
  input  wire logic       reset,
  input  wire logic [7:0] payload,
  input  wire logic       payload_valid,
  output logic            payload_ready,
  output logic [7:0]      status,
  output logic            status_valid,
  output logic            spi_sck,
  output logic            spi_csn,
  output logic            spi_mosi,
  output logic            spi_ce,
  input  wire logic       spi_miso
);

  nrf_link_pkg::spi_item_t seq_item;   // sequencer to fifo
  logic                    seq_valid;
  logic                    seq_ready;
  nrf_link_pkg::spi_item_t spi_item;   // fifo to master
  logic                    spi_valid;
  logic                    spi_ready;

  nrf_tx_sequencer i_nrf_tx_sequencer (
    .clk           (clk),
    .reset         (reset),
    .payload       (payload),
    .payload_valid (payload_valid),
    .payload_ready (payload_ready),
    .item          (seq_item),
    .item_valid    (seq_valid),
    .item_ready    (seq_ready),
    .spi_ce        (spi_ce)
  );

  spi_item_fifo #(
    .item_t (nrf_link_pkg::spi_item_t),
    .depth  (`NRF_FIFO_DEPTH)
  ) i_spi_item_fifo (
    .clk       (clk),
    .reset     (reset),
    .in_item   (seq_item),
    .in_valid  (seq_valid),
    .in_ready  (seq_ready),
    .out_item  (spi_item),
    .out_valid (spi_valid),
    .out_ready (spi_ready)
  );

  nrf_spi_master i_nrf_spi_master (
    .clk          (clk),
    .reset        (reset),
    .item         (spi_item),
    .item_valid   (spi_valid),
    .item_ready   (spi_ready),
    .spi_sck      (spi_sck),
    .spi_csn      (spi_csn),
    .spi_mosi     (spi_mosi),
    .spi_miso     (spi_miso),
    .status       (status),
    .status_valid (status_valid)
  );

endmodule

`default_nettype wire

/* hdl/spi_item_fifo.sv */
// circular valid/ready FIFO with a type parameter for the stored item
`default_nettype none

module spi_item_fifo #(
  parameter type item_t = logic [7:0],
  parameter int  depth  = 4
) (
  input  wire logic  clk,
  input  wire logic  reset,
  input  wire item_t in_item,
  input  wire logic  in_valid,
  output logic       in_ready,
  output item_t      out_item,
  output logic       out_valid,
  input  wire logic  out_ready
);

  localparam int ptr_w = (depth > 1) ? $clog2(depth) : 1;
  localparam int cnt_w = $clog2(depth + 1);

  item_t            mem [depth];
  logic [ptr_w-1:0] wr_ptr;
  logic [ptr_w-1:0] rd_ptr;
  logic [cnt_w-1:0] count;  // occupancy
  logic             push;
  logic             pop;

  // wrap for any depth, not only powers of two
  function automatic logic [ptr_w-1:0] next_ptr(input logic [ptr_w-1:0] ptr);
    next_ptr = (ptr == ptr_w'(depth - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign in_ready = (count != cnt_w'(depth)); // full stalls the producer
  assign out_valid = (count != '0);
  assign out_item = mem[rd_ptr];
  assign push = in_valid && in_ready;
  assign pop = out_valid && out_ready;

  always_ff @(posedge clk) begin
    if (push) mem[wr_ptr] <= in_item;
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count <= '0;
    end else begin
      if (push) wr_ptr <= next_ptr(wr_ptr);
      if (pop) rd_ptr <= next_ptr(rd_ptr);
      if (push && !pop) count <= count + 1'b1;
      else if (pop && !push) count <= count - 1'b1;
    end
  end

endmodule

`default_nettype wire

/* sim/nrf_tx_checker.sv */
// concurrent SPI pin checks, bound into the SPI master of the transmit controller
`default_nettype none
`include "nrf_config.svh"

module nrf_tx_checker (
  input wire logic clk,
  input wire logic reset,
  input wire logic spi_sck,
  input wire logic spi_csn,
  input wire logic spi_mosi
);

  logic       csn_q;    // csn one cycle back
  logic [7:0] gap_cnt;  // cycles since csn rose, saturates

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      csn_q <= 1'b1;
      gap_cnt <= 8'hFF;
    end else begin
      csn_q <= spi_csn;
      if (spi_csn && !csn_q) gap_cnt <= 8'd0;      // frame just closed
      else if (gap_cnt != 8'hFF) gap_cnt <= gap_cnt + 8'd1;
    end
  end

  sck_idle: assert property (@(posedge clk) disable iff (reset) spi_csn |-> !spi_sck)
    else $error("sck high outside a csn frame");

  mosi_hold: assert property (@(posedge clk) disable iff (reset) spi_sck |-> $stable(spi_mosi))
    else $error("mosi changed while sck was high");

  csn_gap: assert property (@(posedge clk) disable iff (reset)
    (gap_cnt < 8'(`NRF_CSN_GAP)) |-> (spi_csn && $stable(spi_sck)))
    else $error("sck or csn moved inside the inter-frame gap");

endmodule

bind nrf_spi_master nrf_tx_checker i_nrf_tx_checker (
  .clk      (clk),
  .reset    (reset),
  .spi_sck  (spi_sck),
  .spi_csn  (spi_csn),
  .spi_mosi (spi_mosi)
);

`default_nettype wire

/* sim/nrf_tx_tb.sv */
// testbench for the nRF24L01 transmit controller: host driver, SPI slave model, frame and status checks
`default_nettype none
`include "nrf_config.svh"

module nrf_tx_tb;

  localparam int n_pass = 8;                       // payload bytes sent by the host
  localparam int n_cfg = 9;                        // setup frames before the loop
  localparam int max_gap = 256;                    // longest host idle stretch
  localparam int byte_cyc = 16 * `NRF_SCK_HALF + 2;
  localparam int gap_cyc = `NRF_CSN_GAP + 4;
  localparam int pass_cyc = 7 * byte_cyc + 4 * gap_cyc + `NRF_TX_SETTLE + max_gap;
  localparam int run_cyc = 16 + `NRF_PWR_ON_WAIT + 22 * byte_cyc + 9 * gap_cyc
                           + n_pass * pass_cyc;

  logic        clk = 1'b0;
  logic        reset;
  logic [7:0]  payload;
  logic        payload_valid;
  logic        payload_ready;
  logic [7:0]  status;
  logic        status_valid;
  logic        spi_sck;
  logic        spi_csn;
  logic        spi_mosi;
  logic        spi_ce;
  logic        spi_miso = 1'b0;

  logic [31:0] lcg_state = 32'd59;   // generator state, fixed seed
  logic [7:0]  payloads [$];         // host bytes in send order
  logic [7:0]  gaps [$];             // idle cycles before each byte
  logic [7:0]  status_vals [$];      // STATUS value per read frame
  logic [55:0] got_frames [$];       // {length, bytes left aligned}
  logic [7:0]  exp_status [$];       // STATUS shifted out in read frames
  int          accepted = 0;
  int          frames_started = 0;
  int          frames_done = 0;
  int          status_count = 0;
  int          read_count = 0;
  logic        ce_seen = 1'b0;

  // slave model state
  logic        prev_sck = 1'b0;
  logic        prev_csn = 1'b1;
  logic [7:0]  shift_in = 8'h00;
  logic [7:0]  miso_sr = 8'h00;
  logic [47:0] frame_data = '0;
  int          bit_cnt = 0;
  int          frame_len = 0;
  logic [55:0] got;
  logic [7:0]  want;

  always #50 clk = ~clk;

  nrf_tx_top i_nrf_tx_top (
    .clk           (clk),
    .reset         (reset),
    .payload       (payload),
    .payload_valid (payload_valid),
    .payload_ready (payload_ready),
    .status        (status),
    .status_valid  (status_valid),
    .spi_sck       (spi_sck),
    .spi_csn       (spi_csn),
    .spi_mosi      (spi_mosi),
    .spi_ce        (spi_ce),
    .spi_miso      (spi_miso)
  );

  //////////////////////////////////////////////////
  // helpers and reference model
  //////////////////////////////////////////////////
  function automatic logic [7:0] next_random();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state[23:16]; // middle bits, low bits cycle too fast
  endfunction

  function automatic logic [55:0] write_frame(input logic [7:0] addr, input logic [7:0] val);
    return {8'd2, nrf_reg_pkg::cmd_w_register | addr, val, 32'd0};
  endfunction

  // frame n of the run as {length, bytes}, first byte in the top byte
  function automatic logic [55:0] expected_frame(input int n);
    logic [55:0] f;
    int          p;
    p = (n - n_cfg) / 4;
    case (n)
      0: f = write_frame(nrf_reg_pkg::reg_config, nrf_reg_pkg::cfg_config);
      1: f = write_frame(nrf_reg_pkg::reg_en_aa, nrf_reg_pkg::cfg_en_aa);
      2: f = write_frame(nrf_reg_pkg::reg_en_rxaddr, nrf_reg_pkg::cfg_en_rxaddr);
      3: f = write_frame(nrf_reg_pkg::reg_setup_aw, nrf_reg_pkg::cfg_setup_aw);
      4: f = write_frame(nrf_reg_pkg::reg_rf_ch, nrf_reg_pkg::cfg_rf_ch);
      5: f = write_frame(nrf_reg_pkg::reg_rf_setup, nrf_reg_pkg::cfg_rf_setup);
      6: f = write_frame(nrf_reg_pkg::reg_setup_retr, nrf_reg_pkg::cfg_setup_retr);
      7: f = write_frame(nrf_reg_pkg::reg_rx_pw_p0, nrf_reg_pkg::cfg_rx_pw_p0);
      8: f = {8'd6, nrf_reg_pkg::cmd_w_register | nrf_reg_pkg::reg_tx_addr,
              {5{nrf_reg_pkg::cfg_tx_addr_byte}}};
      default: begin
        case ((n - n_cfg) % 4)
          0: f = {8'd1, nrf_reg_pkg::cmd_flush_tx, 40'd0};
          1: f = write_frame(nrf_reg_pkg::reg_status, nrf_reg_pkg::cfg_status_clear);
          2: f = {8'd2, nrf_reg_pkg::cmd_w_tx_payload, payloads[p], 32'd0};
          default: f = {8'd2, nrf_reg_pkg::cmd_r_register | nrf_reg_pkg::reg_status,
                        nrf_reg_pkg::cmd_nop, 32'd0};
        endcase
      end
    endcase
    return f;
  endfunction

  task automatic abort_run();
    $display("Something failed");
    $fatal(1, "simulation stopped at the first failure");
  endtask

  task automatic report_error(input string msg);
    $display("** Error at time %0t: %s", $time, msg);
    abort_run();
  endtask

  //////////////////////////////////////////////////
  // SPI slave model, acts just after each clk edge
  //////////////////////////////////////////////////
  always @(posedge clk) begin
    #10;
    if (prev_csn && !spi_csn) begin              // frame opens
      frame_data = '0;
      frame_len = 0;
      bit_cnt = 0;
      miso_sr = status_vals[read_count];
      frames_started++;
    end
    if (!spi_csn && !prev_sck && spi_sck) begin  // master took a miso bit on this edge too
      shift_in = {shift_in[6:0], spi_mosi};
      miso_sr = {miso_sr[6:0], 1'b0};
      bit_cnt++;
      if (bit_cnt == 8) begin
        frame_data = {frame_data[39:0], shift_in};
        frame_len++;
        bit_cnt = 0;
        miso_sr = status_vals[read_count];         // STATUS again on every byte
      end
    end
    if (!prev_csn && spi_csn) begin              // frame closes
      if (frame_len < 6) frame_data = frame_data << (8 * (6 - frame_len));
      got_frames.push_back({8'(frame_len), frame_data});
      if (frame_data[47:40] == (nrf_reg_pkg::cmd_r_register | nrf_reg_pkg::reg_status)) begin
        exp_status.push_back(status_vals[read_count]);
        read_count++;                              // next pass reports a new value
      end
    end
    spi_miso = miso_sr[7];
    prev_sck = spi_sck;
    prev_csn = spi_csn;
  end

  //////////////////////////////////////////////////
  // comparison at the falling clk edge
  //////////////////////////////////////////////////
  always @(negedge clk) begin
    if (!reset) begin
      if (!ce_seen) begin
        assert (spi_csn && !spi_sck && !spi_mosi && !status_valid && !payload_ready)
          else report_error("outputs left their idle level before ce rose");
      end else begin
        assert (spi_ce) else report_error("ce went low after power-on");
      end
      if (spi_ce) ce_seen = 1'b1;
      assert (frames_started <= n_cfg + 4 * accepted)
        else report_error($sformatf("frame %0d started with only %0d payloads accepted",
                                    frames_started - 1, accepted));
      if (got_frames.size() > 0) begin
        got = got_frames.pop_front();
        assert (frames_done < n_cfg + 4 * n_pass)
          else report_error($sformatf("unexpected extra frame %h", got));
        assert (got == expected_frame(frames_done))
          else report_error($sformatf("frame %0d is %h, expected %h", frames_done, got,
                                      expected_frame(frames_done)));
        frames_done++;
      end
      if (status_valid) begin
        assert (exp_status.size() > 0)
          else report_error("status pulse without a finished read frame");
        want = exp_status.pop_front();
        assert (status == want)
          else report_error($sformatf("status %h, expected %h", status, want));
        status_count++;
      end
    end
  end

  //////////////////////////////////////////////////
  // host driver and end of run
  //////////////////////////////////////////////////
  initial begin
    reset = 1'b1;
    payload = 8'h00;
    payload_valid = 1'b0;
    for (int i = 0; i < n_pass; i++) begin
      payloads.push_back(next_random());
      gaps.push_back(next_random());             // 0 to 255 idle cycles
    end
    for (int i = 0; i <= n_pass; i++) status_vals.push_back(next_random());
    repeat (16) @(posedge clk);
    #10 reset = 1'b0;
    for (int p = 0; p < n_pass; p++) begin
      if (p > 0) wait (status_count == p);       // idle stretch starts once the pass is done
      repeat (int'(gaps[p])) @(posedge clk);
      #10;
      payload = payloads[p];
      payload_valid = 1'b1;
      do @(negedge clk); while (!payload_ready);   // taken at the next rising edge
      @(posedge clk);
      #10;
      payload_valid = 1'b0;
      accepted++;
    end
    wait (status_count == n_pass);
    repeat (4 * byte_cyc) @(negedge clk);        // loop must stay quiet without a payload
    if (frames_done == n_cfg + 4 * n_pass && frames_started == frames_done &&
        exp_status.size() == 0) begin
      $display("Everything OK");
      $finish;
    end else begin
      report_error($sformatf("run ended with %0d frames started and %0d checked",
                             frames_started, frames_done));
    end
  end

  initial begin
    #(200 * run_cyc);                            // twice the worst-case run
    $display("timeout: the run did not finish within %0d clock cycles", 2 * run_cyc);
    abort_run();
  end

endmodule

`default_nettype wire

/* vlog.f */
+incdir+hdl
hdl/nrf_reg_pkg.sv
hdl/nrf_link_pkg.sv
hdl/spi_item_fifo.sv
hdl/nrf_tx_sequencer.sv
hdl/nrf_spi_master.sv
hdl/nrf_tx_top.sv
sim/nrf_tx_checker.sv
sim/nrf_tx_tb.sv
